/* uart_cfg_pkg.sv */
package uart_cfg_pkg;

	// frame layout: start, data LSB first, even parity, stop
	localparam int DATA_WIDTH   = 8;  // payload bits per frame
	localparam int CLKS_PER_BIT = 8;  // tx_clk cycles per serial bit

	localparam int SYNC_STAGES  = 3;  // flops on the receive line before any decode

	localparam int FRAME_BITS   = 1 + DATA_WIDTH + 1 + 1;  // start + data + parity + stop

	// counter widths
	localparam int BIT_CNT_W    = $clog2(FRAME_BITS + 1);    // bit index inside a frame
	localparam int TICK_CNT_W   = $clog2(CLKS_PER_BIT + 1);  // holds 0..CLKS_PER_BIT

	// receiver samples on this tick of each bit, roughly the middle
	localparam int SAMPLE_POINT = CLKS_PER_BIT / 2;

endpackage

/* uart_types_pkg.sv */
package uart_types_pkg;

	// transmitter position in the frame
	typedef enum logic [2:0] {
		tx_idle   = 3'd0,  // line held high, waiting for enable
		tx_start  = 3'd1,  // start bit low on the line
		tx_data   = 3'd2,  // data bits, LSB first
		tx_parity = 3'd3,  // even parity of the word
		tx_stop   = 3'd4   // stop bit high
	} tx_state_e;

	// receiver position in the frame
	typedef enum logic [2:0] {
		rx_idle   = 3'd0,  // hunting for a falling edge
		rx_start  = 3'd1,  // start bit confirmed at mid-bit
		rx_data   = 3'd2,  // shifting in data bits
		rx_parity = 3'd3,  // capture parity bit
		rx_stop   = 3'd4   // check stop bit, report word
	} rx_state_e;

endpackage

/* uart_tx_if.sv */
`timescale 1ns/10ps

// transmitter side of the loop, seen by the checker and the top level
interface uart_tx_if;

	logic                                launch;   // one cycle, first cycle of the start bit
	logic [uart_cfg_pkg::DATA_WIDTH-1:0] word;     // latched word, stable while busy
	logic                                busy;     // frame on the line
	logic                                tx_line;  // serial line as driven

	modport src (
		output launch,
		output word,
		output busy,
		output tx_line
	);

	modport dst (
		input launch,
		input word,
		input busy,
		input tx_line
	);

endinterface

/* uart_rx_if.sv */
`timescale 1ns/10ps

// receiver results, updated together at the stop-bit sample
interface uart_rx_if;

	logic                                valid;       // one-cycle pulse per received word
	logic [uart_cfg_pkg::DATA_WIDTH-1:0] data;        // last received word
	logic                                parity_err;  // even parity failed on last word
	logic                                stop_err;    // stop bit sampled low on last word

	modport src (
		output valid,
		output data,
		output parity_err,
		output stop_err
	);

	modport dst (
		input valid,
		input data,
		input parity_err,
		input stop_err
	);

endinterface

/* uart_tx.sv */
`timescale 1ns/10ps

module uart_tx (
	input  logic                                tx_clk,
	input  logic                                reset_tx,
	input  logic                                i_enable,
	input  logic [uart_cfg_pkg::DATA_WIDTH-1:0] i_data,
	uart_tx_if.src                              tx_bus,
	output logic                                o_serial_out
);

	logic                                  accept;    // enable seen while idle
	logic                                  bit_end;   // last clock of the current bit
	uart_types_pkg::tx_state_e             state_q;
	logic [uart_cfg_pkg::TICK_CNT_W-1:0]   tick_q;    // clocks into the current bit
	logic [uart_cfg_pkg::BIT_CNT_W-1:0]    bit_q;     // data bit index
	logic [uart_cfg_pkg::FRAME_BITS-2:0]   shift_q;   // data, parity, stop still to send
	logic [uart_cfg_pkg::DATA_WIDTH-1:0]   word_q;    // launched word for the checker
	logic                                  serial_q;
	logic                                  busy_q;
	logic                                  launch_q;

	assign accept  = i_enable & ~busy_q;  // enable during a frame is dropped
	assign bit_end = busy_q &
		(tick_q == uart_cfg_pkg::TICK_CNT_W'(uart_cfg_pkg::CLKS_PER_BIT - 1));

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			state_q  <= uart_types_pkg::tx_idle;
			tick_q   <= '0;
			bit_q    <= '0;
			serial_q <= 1'b1;  // idle line is high
			busy_q   <= 1'b0;
			launch_q <= 1'b0;
		end else begin
			launch_q <= accept;
			if (accept) begin
				state_q  <= uart_types_pkg::tx_start;
				tick_q   <= '0;
				bit_q    <= '0;
				serial_q <= 1'b0;  // start bit goes out with busy
				busy_q   <= 1'b1;
			end else if (busy_q) begin
				tick_q <= bit_end ? '0 : tick_q + 1'b1;
				if (bit_end) begin
					serial_q <= shift_q[0];  // next bit, stop fill keeps line high at end
					case (state_q)
						uart_types_pkg::tx_start: begin
							state_q <= uart_types_pkg::tx_data;
						end
						uart_types_pkg::tx_data: begin
							if (bit_q == uart_cfg_pkg::BIT_CNT_W'(uart_cfg_pkg::DATA_WIDTH - 1))
								state_q <= uart_types_pkg::tx_parity;
							else
								bit_q <= bit_q + 1'b1;
						end
						uart_types_pkg::tx_parity: begin
							state_q <= uart_types_pkg::tx_stop;
						end
						uart_types_pkg::tx_stop: begin
							state_q <= uart_types_pkg::tx_idle;
							busy_q  <= 1'b0;  // drops right after the stop bit's last clock
						end
						default: begin
							state_q <= uart_types_pkg::tx_idle;
							busy_q  <= 1'b0;
						end
					endcase
				end
			end
		end
	end

	// payload path
	always_ff @(posedge tx_clk) begin
		if (accept) begin
			word_q  <= i_data;
			shift_q <= {1'b1, ^i_data, i_data};  // stop, even parity, data
		end else if (bit_end) begin
			shift_q <= {1'b1, shift_q[uart_cfg_pkg::FRAME_BITS-2:1]};  // refill with idle level
		end
	end

	assign o_serial_out   = serial_q;
	assign tx_bus.tx_line = serial_q;
	assign tx_bus.busy    = busy_q;
	assign tx_bus.launch  = launch_q;
	assign tx_bus.word    = word_q;

	// busy covers exactly one frame of bit periods
	a_busy_frame: assert property (@(posedge tx_clk) disable iff (reset_tx)
		$rose(busy_q) |->
			##(uart_cfg_pkg::FRAME_BITS * uart_cfg_pkg::CLKS_PER_BIT) $fell(busy_q));

	a_launch_single: assert property (@(posedge tx_clk) disable iff (reset_tx)
		launch_q |=> !launch_q);

endmodule

/* uart_rx.sv */
`timescale 1ns/10ps

module uart_rx (
	input  logic   tx_clk,
	input  logic   reset_tx,
	input  logic   i_loopback,  // high takes the transmitter line
	input  logic   i_tx_line,
	input  logic   i_ext_line,
	uart_rx_if.src rx_bus
);

	logic                                   line_sel;
	logic [uart_cfg_pkg::SYNC_STAGES-1:0]   sync_q;       // oldest sample in the top bit
	logic                                   line_synced;
	logic                                   line_prev_q;  // synced line one cycle ago
	logic                                   fall_edge;
	logic                                   sample;       // mid-bit strobe
	uart_types_pkg::rx_state_e              state_q;
	logic [uart_cfg_pkg::TICK_CNT_W-1:0]    tick_q;       // counts 1..CLKS_PER_BIT
	logic [uart_cfg_pkg::BIT_CNT_W-1:0]     bit_q;
	logic [uart_cfg_pkg::DATA_WIDTH-1:0]    shift_q;      // assembles word LSB first
	logic                                   parity_q;
	logic [uart_cfg_pkg::DATA_WIDTH-1:0]    data_q;
	logic                                   valid_q;
	logic                                   parity_err_q;
	logic                                   stop_err_q;

	assign line_sel    = i_loopback ? i_tx_line : i_ext_line;
	assign line_synced = sync_q[uart_cfg_pkg::SYNC_STAGES-1];
	assign fall_edge   = line_prev_q & ~line_synced;  // high to low on the synced line
	assign sample      = (state_q != uart_types_pkg::rx_idle) &
		(tick_q == uart_cfg_pkg::TICK_CNT_W'(uart_cfg_pkg::SAMPLE_POINT));

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			sync_q      <= '1;  // assume idle line out of reset
			line_prev_q <= 1'b1;
		end else begin
			sync_q      <= {sync_q[uart_cfg_pkg::SYNC_STAGES-2:0], line_sel};
			line_prev_q <= line_synced;
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			state_q      <= uart_types_pkg::rx_idle;
			tick_q       <= '0;
			bit_q        <= '0;
			data_q       <= '0;
			valid_q      <= 1'b0;
			parity_err_q <= 1'b0;
			stop_err_q   <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			if (state_q == uart_types_pkg::rx_idle) begin
				if (fall_edge) begin
					state_q <= uart_types_pkg::rx_start;
					tick_q  <= uart_cfg_pkg::TICK_CNT_W'(2);  // edge was the first clock of start
					bit_q   <= '0;
				end
			end else begin
				if (tick_q == uart_cfg_pkg::TICK_CNT_W'(uart_cfg_pkg::CLKS_PER_BIT))
					tick_q <= uart_cfg_pkg::TICK_CNT_W'(1);
				else
					tick_q <= tick_q + 1'b1;
				if (sample) begin
					case (state_q)
						uart_types_pkg::rx_start: begin
							// glitch shorter than half a bit goes back to hunting
							state_q <= line_synced ? uart_types_pkg::rx_idle
							                       : uart_types_pkg::rx_data;
						end
						uart_types_pkg::rx_data: begin
							if (bit_q == uart_cfg_pkg::BIT_CNT_W'(uart_cfg_pkg::DATA_WIDTH - 1))
								state_q <= uart_types_pkg::rx_parity;
							else
								bit_q <= bit_q + 1'b1;
						end
						uart_types_pkg::rx_parity: begin
							state_q <= uart_types_pkg::rx_stop;
						end
						uart_types_pkg::rx_stop: begin
							state_q      <= uart_types_pkg::rx_idle;  // rest of stop bit is idle time
							valid_q      <= 1'b1;
							data_q       <= shift_q;
							parity_err_q <= (^shift_q) ^ parity_q;  // even parity over data + parity
							stop_err_q   <= ~line_synced;
						end
						default: begin
							state_q <= uart_types_pkg::rx_idle;
						end
					endcase
				end
			end
		end
	end

	// data and parity capture
	always_ff @(posedge tx_clk) begin
		if (sample && (state_q == uart_types_pkg::rx_data))
			shift_q <= {line_synced, shift_q[uart_cfg_pkg::DATA_WIDTH-1:1]};
		if (sample && (state_q == uart_types_pkg::rx_parity))
			parity_q <= line_synced;
	end

	assign rx_bus.valid      = valid_q;
	assign rx_bus.data       = data_q;
	assign rx_bus.parity_err = parity_err_q;
	assign rx_bus.stop_err   = stop_err_q;

	a_valid_pulse: assert property (@(posedge tx_clk) disable iff (reset_tx)
		valid_q |=> !valid_q);

	// a high line never starts a frame
	a_idle_hold: assert property (@(posedge tx_clk) disable iff (reset_tx)
		(state_q == uart_types_pkg::rx_idle) && line_synced |=>
			state_q == uart_types_pkg::rx_idle);

endmodule

/* loop_checker.sv */
`timescale 1ns/10ps

module loop_checker (
	input  logic    tx_clk,
	input  logic    reset_tx,
	uart_tx_if.dst  tx_bus,
	uart_rx_if.dst  rx_bus,
	output logic    o_loop_ok,
	output logic    o_loop_fail
);

	logic                                armed_q;   // a launched word awaits its receipt
	logic [uart_cfg_pkg::DATA_WIDTH-1:0] word_q;    // word sent by the last launch
	logic                                word_good;
	logic                                ok_q;
	logic                                fail_q;

	// receiver fields are updated with valid, so they line up here
	assign word_good = (rx_bus.data == word_q) & ~rx_bus.parity_err & ~rx_bus.stop_err;

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			armed_q <= 1'b0;
			ok_q    <= 1'b0;
			fail_q  <= 1'b0;
		end else begin
			ok_q   <= rx_bus.valid & armed_q & word_good;   // verdict one cycle after valid
			fail_q <= rx_bus.valid & armed_q & ~word_good;
			if (tx_bus.launch)
				armed_q <= 1'b1;  // a new launch wins over a same-cycle receipt
			else if (rx_bus.valid)
				armed_q <= 1'b0;
		end
	end

	always_ff @(posedge tx_clk) begin
		if (tx_bus.launch)
			word_q <= tx_bus.word;  // overwrites any word still waiting
	end

	assign o_loop_ok   = ok_q;
	assign o_loop_fail = fail_q;

	a_one_verdict: assert property (@(posedge tx_clk) disable iff (reset_tx)
		!(o_loop_ok && o_loop_fail));

endmodule

/* uart_loop_top.sv */
`timescale 1ns/10ps

module uart_loop_top (
	input  logic                                tx_clk,
	input  logic                                reset_tx,
	input  logic                                i_enable,
	input  logic [uart_cfg_pkg::DATA_WIDTH-1:0] i_data,
	input  logic                                i_loopback,   // 1 = internal loop, 0 = i_serial_in
	input  logic                                i_serial_in,
	output logic                                o_serial_out,
	output logic                                o_busy,
	output logic [uart_cfg_pkg::DATA_WIDTH-1:0] o_rx_data,
	output logic                                o_rx_valid,
	output logic                                o_rx_error,
	output logic                                o_loop_ok,
	output logic                                o_loop_fail
);

	uart_tx_if tx_bus ();
	uart_rx_if rx_bus ();

	uart_tx u_tx (
		.tx_clk       (tx_clk),
		.reset_tx     (reset_tx),
		.i_enable     (i_enable),
		.i_data       (i_data),
		.tx_bus       (tx_bus.src),
		.o_serial_out (o_serial_out)
	);

	uart_rx u_rx (
		.tx_clk     (tx_clk),
		.reset_tx   (reset_tx),
		.i_loopback (i_loopback),
		.i_tx_line  (tx_bus.tx_line),  // loop path taken inside the receiver
		.i_ext_line (i_serial_in),
		.rx_bus     (rx_bus.src)
	);

	loop_checker u_checker (
		.tx_clk      (tx_clk),
		.reset_tx    (reset_tx),
		.tx_bus      (tx_bus.dst),
		.rx_bus      (rx_bus.dst),
		.o_loop_ok   (o_loop_ok),
		.o_loop_fail (o_loop_fail)
	);

	assign o_busy     = tx_bus.busy;
	assign o_rx_data  = rx_bus.data;
	assign o_rx_valid = rx_bus.valid;
	assign o_rx_error = rx_bus.parity_err | rx_bus.stop_err;  // either fault on the last word

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
	output logic o_tx_clk,
	output logic o_reset_tx
);

	initial begin
		o_tx_clk = 1'b0;
		forever #2 o_tx_clk = ~o_tx_clk;  // 4 ns period
	end

	initial begin
		o_reset_tx = 1'b1;
		repeat (10) @(posedge o_tx_clk);  // ten full cycles in reset
		o_reset_tx <= 1'b0;
	end

endmodule

/* tb_uart_loop.sv */
`timescale 1ns/10ps

module tb_uart_loop;

	localparam int DW          = uart_cfg_pkg::DATA_WIDTH;
	localparam int CPB         = uart_cfg_pkg::CLKS_PER_BIT;
	localparam int FB          = uart_cfg_pkg::FRAME_BITS;
	localparam int FRAME_CLKS  = FB * CPB;  // busy length of one frame
	localparam int ENTRY_LIMIT = 150;       // cycles allowed for one word to come back
	localparam int NUM_ENTRIES = 12;
	localparam logic MODE_LOOP = 1'b0;
	localparam logic MODE_EXT  = 1'b1;
	localparam logic [1:0] V_NONE = 2'd0;   // no verdict expected
	localparam logic [1:0] V_OK   = 2'd1;
	localparam logic [1:0] V_FAIL = 2'd2;

	typedef struct packed {
		logic          mode;         // loopback or external frame
		logic          launch;       // pulse i_enable for this entry
		logic          second_en;    // extra enable in the middle of the frame
		logic [DW-1:0] data;
		logic          bad_par;      // external frame only
		logic          bad_stop;     // external frame only
		logic          exp_err;
		logic [1:0]    exp_verdict;
	} entry_t;

	logic          tx_clk;
	logic          reset_tx;
	logic          i_enable;
	logic [DW-1:0] i_data;
	logic          i_loopback;
	logic          i_serial_in;
	logic          o_serial_out;
	logic          o_busy;
	logic [DW-1:0] o_rx_data;
	logic          o_rx_valid;
	logic          o_rx_error;
	logic          o_loop_ok;
	logic          o_loop_fail;
	entry_t        entries[$];
	int            errors;
	int            checks;
	logic [31:0]   lcg_state;

	tb_clock_gen u_clk (
		.o_tx_clk   (tx_clk),
		.o_reset_tx (reset_tx)
	);

	uart_loop_top i_dut (
		.tx_clk       (tx_clk),
		.reset_tx     (reset_tx),
		.i_enable     (i_enable),
		.i_data       (i_data),
		.i_loopback   (i_loopback),
		.i_serial_in  (i_serial_in),
		.o_serial_out (o_serial_out),
		.o_busy       (o_busy),
		.o_rx_data    (o_rx_data),
		.o_rx_valid   (o_rx_valid),
		.o_rx_error   (o_rx_error),
		.o_loop_ok    (o_loop_ok),
		.o_loop_fail  (o_loop_fail)
	);

	function automatic logic [DW-1:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];  // upper bits cycle better than the low ones
	endfunction

	// reference frame with bit 0 first on the line
	function automatic logic [FB-1:0] frame_bits(input logic [DW-1:0] data,
		input logic bad_par, input logic bad_stop);
		logic parity;
		int   i;
		parity = 1'b0;
		for (i = 0; i < DW; i++)
			parity = parity ^ data[i];  // even parity
		return {~bad_stop, parity ^ bad_par, data, 1'b0};
	endfunction

	function automatic logic bit_at(input logic [FB-1:0] frame, input int pos);
		logic [FB-1:0] shifted;
		shifted = frame >> pos;
		return shifted[0];
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Error at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	task automatic add_entry(input logic mode, input logic launch, input logic second_en,
		input logic [DW-1:0] data, input logic bad_par, input logic bad_stop,
		input logic exp_err, input logic [1:0] exp_verdict);
		entry_t e;
		e = '{mode, launch, second_en, data, bad_par, bad_stop, exp_err, exp_verdict};
		entries.push_back(e);
	endtask

	task automatic build_table();
		int i;
		add_entry(MODE_LOOP, 1'b1, 1'b0, 8'h55, 1'b0, 1'b0, 1'b0, V_OK);
		add_entry(MODE_LOOP, 1'b1, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0, V_OK);
		add_entry(MODE_LOOP, 1'b1, 1'b1, 8'ha7, 1'b0, 1'b0, 1'b0, V_OK);    // late enable dropped
		add_entry(MODE_EXT,  1'b0, 1'b0, 8'h3c, 1'b1, 1'b0, 1'b1, V_NONE);  // parity flipped
		add_entry(MODE_EXT,  1'b0, 1'b0, 8'h81, 1'b0, 1'b1, 1'b1, V_NONE);  // stop bit low
		add_entry(MODE_EXT,  1'b0, 1'b0, 8'he4, 1'b0, 1'b0, 1'b0, V_NONE);
		add_entry(MODE_EXT,  1'b1, 1'b0, 8'h96, 1'b1, 1'b0, 1'b1, V_FAIL);  // armed with a bad receipt
		for (i = entries.size(); i < NUM_ENTRIES; i++)
			add_entry(MODE_LOOP, 1'b1, 1'b0, next_random(), 1'b0, 1'b0, 1'b0, V_OK);
	endtask

	task automatic run_entry(input int idx, input entry_t e);
		logic [FB-1:0]             tx_ref;
		logic [FB-1:0]             ext_ref;
		int                        c;
		int                        settle;
		int                        busy_cnt;
		int                        valid_cnt;
		int                        ok_cnt;
		int                        fail_cnt;
		uart_types_pkg::tx_state_e st;
		tx_ref    = frame_bits(e.data, 1'b0, 1'b0);
		ext_ref   = frame_bits(e.data, e.bad_par, e.bad_stop);
		c         = 0;
		settle    = 0;
		busy_cnt  = 0;
		valid_cnt = 0;
		ok_cnt    = 0;
		fail_cnt  = 0;
		@(negedge tx_clk);
		st = i_dut.u_tx.state_q;
		if (st != uart_types_pkg::tx_idle) begin
			errors++;
			$display("entry %0d: transmitter is in state %s instead of idle", idx, st.name());
		end
		@(posedge tx_clk);
		i_loopback <= ~e.mode;
		i_enable   <= e.launch;
		i_data     <= e.data;
		@(posedge tx_clk);  // enable taken here and cycle 0 starts
		i_enable <= 1'b0;
		if (e.mode == MODE_EXT)
			i_serial_in <= bit_at(ext_ref, 0);  // start bit lined up with the transmitter
		while (settle < 4) begin
			@(negedge tx_clk);
			if (o_busy)
				busy_cnt++;
			if (e.launch && (c < FRAME_CLKS) && (c % CPB == CPB / 2))
				compare("o_serial_out", 32'(bit_at(tx_ref, c / CPB)), 32'(o_serial_out));
			if (o_rx_valid) begin
				valid_cnt++;
				compare("o_rx_data", 32'(e.data), 32'(o_rx_data));
				compare("o_rx_error", 32'(e.exp_err), 32'(o_rx_error));
				if (e.mode == MODE_LOOP)
					compare("o_busy at o_rx_valid", 32'd1, 32'(o_busy));
			end
			if (o_loop_ok)
				ok_cnt++;
			if (o_loop_fail)
				fail_cnt++;
			if ((valid_cnt > 0) && !o_busy && (c >= FRAME_CLKS))
				settle++;  // a few quiet cycles to catch a late verdict
			if ((c >= ENTRY_LIMIT) && (settle == 0)) begin
				errors++;
				$display("entry %0d: no word received within %0d cycles", idx, ENTRY_LIMIT);
				settle = 4;
			end
			@(posedge tx_clk);
			if (e.second_en && (c == 19)) begin
				i_enable <= 1'b1;      // busy is high so this enable is ignored
				i_data   <= ~e.data;
			end else begin
				i_enable <= 1'b0;
			end
			if (e.mode == MODE_EXT)
				i_serial_in <= (c + 1 < FRAME_CLKS) ? bit_at(ext_ref, (c + 1) / CPB) : 1'b1;
			c++;
		end
		i_serial_in <= 1'b1;
		compare("o_busy high cycles", 32'(e.launch ? FRAME_CLKS : 0), 32'(busy_cnt));
		compare("o_rx_valid pulses", 32'd1, 32'(valid_cnt));
		compare("o_loop_ok pulses", 32'(e.exp_verdict == V_OK), 32'(ok_cnt));
		compare("o_loop_fail pulses", 32'(e.exp_verdict == V_FAIL), 32'(fail_cnt));
	endtask

	initial begin
		int i;
		errors      = 0;
		checks      = 0;
		lcg_state   = 32'd97943;
		i_enable    = 1'b0;
		i_data      = '0;
		i_loopback  = 1'b1;
		i_serial_in = 1'b1;  // idle line
		build_table();
		@(negedge tx_clk);
		while (reset_tx)
			@(negedge tx_clk);
		compare("o_busy", 32'd0, 32'(o_busy));
		compare("o_rx_valid", 32'd0, 32'(o_rx_valid));
		compare("o_rx_error", 32'd0, 32'(o_rx_error));
		compare("o_loop_ok", 32'd0, 32'(o_loop_ok));
		compare("o_loop_fail", 32'd0, 32'(o_loop_fail));
		compare("o_serial_out", 32'd1, 32'(o_serial_out));
		compare("o_rx_data", 32'd0, 32'(o_rx_data));
		for (i = 0; i < entries.size(); i++)
			run_entry(i, entries[i]);
		repeat (2) @(posedge tx_clk);
		$display("entries %0d, checks %0d, errors %0d", entries.size(), checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// watchdog
	initial begin
		repeat (NUM_ENTRIES * 200 + 10) @(posedge tx_clk);
		$display("watchdog expired after %0d cycles, the run did not finish",
			NUM_ENTRIES * 200 + 10);
		$display("test failed");
		$finish;
	end

endmodule

/* uart_loop.f */
uart_cfg_pkg.sv
uart_types_pkg.sv
uart_tx_if.sv
uart_rx_if.sv
uart_tx.sv
uart_rx.sv
loop_checker.sv
uart_loop_top.sv
tb_clock_gen.sv
tb_uart_loop.sv

/* run_uart_loop.sh */
#!/bin/sh
# build the UART loopback testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim_uart_loop.log
BIN=obj_dir/tb_uart_loop

verilator --binary --timing --assert -j 0 \
	--top-module tb_uart_loop \
	-f uart_loop.f \
	-o tb_uart_loop
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the testbench prints the pass line only when every check held
if grep -qx "test passed" "$LOG"; then
	echo "run passed"
	exit 0
fi
echo "run failed, see $LOG"
exit 1
